/* hdl/rv_exec_pkg.sv */
package rv_exec_pkg;

  // ==================================================
  // Encodings
  // ==================================================

  // RV32I major opcodes.
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_AUIPC  = 7'b0010111
  } opcode_e;

  typedef enum logic [2:0] {
    CLS_REG,
    CLS_IMM,
    CLS_UPPER,
    CLS_BRANCH,
    CLS_ILLEGAL
  } instr_class_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B      // LUI goes straight through.
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_NONE
  } branch_op_e;

  // ==================================================
  // Structs
  // ==================================================

  typedef struct packed {
    instr_class_e instr_class;
    alu_op_e      alu_op;
    branch_op_e   branch_op;
    logic         use_imm;
    logic         wr_en;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
  } decode_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
  } exec_req_t;

  typedef struct packed {
    logic done;
    logic taken;
    logic illegal;
  } exec_rsp_t;

  // APB register map.
  localparam logic [7:0] REG_INSTR  = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h04;
  localparam logic [7:0] REG_RSEL   = 8'h08;
  localparam logic [7:0] REG_RDATA  = 8'h0C;

endpackage

/* hdl/instruction_decode.sv */
module instruction_decode import rv_exec_pkg::*; (
  input  logic [31:0] i_instr,
  output decode_t     o_dec
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;

  assign opcode  = opcode_e'(i_instr[6:0]);
  assign funct3  = i_instr[14:12];
  assign funct7  = i_instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);  // SUB and SRA(I).

  always_comb begin
    o_dec.instr_class = CLS_ILLEGAL;
    o_dec.alu_op      = ALU_ADD;
    o_dec.branch_op   = BR_NONE;
    o_dec.use_imm     = 1'b0;
    o_dec.wr_en       = 1'b0;
    o_dec.rd          = i_instr[11:7];
    o_dec.rs1         = i_instr[19:15];
    o_dec.rs2         = i_instr[24:20];

    case (opcode)
      OP_REG: begin
        o_dec.instr_class = CLS_REG;
        o_dec.wr_en       = 1'b1;
        case (funct3)
          3'b000:  o_dec.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
          3'b001:  o_dec.alu_op = ALU_SLL;
          3'b010:  o_dec.alu_op = ALU_SLT;
          3'b011:  o_dec.alu_op = ALU_SLTU;
          3'b100:  o_dec.alu_op = ALU_XOR;
          3'b101:  o_dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110:  o_dec.alu_op = ALU_OR;
          default: o_dec.alu_op = ALU_AND;
        endcase
        // Only ADD/SUB and SRL/SRA may carry the alternate funct7.
        if (!(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          o_dec.instr_class = CLS_ILLEGAL;
          o_dec.wr_en       = 1'b0;
        end
      end

      OP_IMM: begin
        o_dec.instr_class = CLS_IMM;
        o_dec.use_imm     = 1'b1;
        o_dec.wr_en       = 1'b1;
        case (funct3)
          3'b000:  o_dec.alu_op = ALU_ADD;
          3'b001:  o_dec.alu_op = ALU_SLL;
          3'b010:  o_dec.alu_op = ALU_SLT;
          3'b011:  o_dec.alu_op = ALU_SLTU;
          3'b100:  o_dec.alu_op = ALU_XOR;
          3'b101:  o_dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110:  o_dec.alu_op = ALU_OR;
          default: o_dec.alu_op = ALU_AND;
        endcase
        if ((funct3 == 3'b001 && !f7_zero) || (funct3 == 3'b101 && !(f7_zero || f7_alt))) begin
          o_dec.instr_class = CLS_ILLEGAL;  // Bad shift encoding.
          o_dec.wr_en       = 1'b0;
        end
      end

      OP_LUI: begin
        o_dec.instr_class = CLS_UPPER;
        o_dec.alu_op      = ALU_PASS_B;
        o_dec.use_imm     = 1'b1;
        o_dec.wr_en       = 1'b1;
      end

      OP_BRANCH: begin
        o_dec.instr_class = CLS_BRANCH;
        case (funct3)
          3'b000:  o_dec.branch_op = BR_EQ;
          3'b001:  o_dec.branch_op = BR_NE;
          3'b100:  o_dec.branch_op = BR_LT;
          3'b101:  o_dec.branch_op = BR_GE;
          3'b110:  o_dec.branch_op = BR_LTU;
          3'b111:  o_dec.branch_op = BR_GEU;
          default: o_dec.instr_class = CLS_ILLEGAL;
        endcase
      end

      // No data memory and no PC here.
      OP_LOAD, OP_STORE, OP_JAL, OP_JALR, OP_AUIPC: o_dec.instr_class = CLS_ILLEGAL;

      default: o_dec.instr_class = CLS_ILLEGAL;
    endcase
  end

endmodule

/* hdl/immediate_gen.sv */
module immediate_gen import rv_exec_pkg::*; (
  input  logic [31:0]  i_instr,
  input  instr_class_e i_class,
  output logic [31:0]  o_imm
);

  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_u;

  // Shift amounts sit in imm_i[4:0]; the ALU ignores the upper bits.
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};

  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                  i_instr[30:25], i_instr[11:8], 1'b0};

  assign imm_u = {i_instr[31:12], 12'b0};

  always_comb begin
    case (i_class)
      CLS_IMM:    o_imm = imm_i;
      CLS_UPPER:  o_imm = imm_u;
      CLS_BRANCH: o_imm = imm_b;  // Offset only, nothing consumes it yet.
      default:    o_imm = '0;
    endcase
  end

endmodule

/* hdl/int_alu.sv */
module int_alu import rv_exec_pkg::*; (
  input  logic [31:0] i_a,
  input  logic [31:0] i_b,
  input  alu_op_e     i_op,
  input  branch_op_e  i_br,
  output logic [31:0] o_result,
  output logic        o_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = i_b[4:0];
  assign eq    = (i_a == i_b);
  assign lt_s  = ($signed(i_a) < $signed(i_b));
  assign lt_u  = (i_a < i_b);

  // ==================================================
  // Result path
  // ==================================================
  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SLT:    o_result = {31'b0, lt_s};
      ALU_SLTU:   o_result = {31'b0, lt_u};
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SRL:    o_result = i_a >> shamt;
      ALU_SRA:    o_result = $signed(i_a) >>> shamt;  // Keeps the sign bit.
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

  // ==================================================
  // Branch compare
  // ==================================================
  always_comb begin
    case (i_br)
      BR_EQ:   o_taken = eq;
      BR_NE:   o_taken = !eq;
      BR_LT:   o_taken = lt_s;
      BR_GE:   o_taken = !lt_s;
      BR_LTU:  o_taken = lt_u;
      BR_GEU:  o_taken = !lt_u;
      default: o_taken = 1'b0;
    endcase
  end

endmodule

/* hdl/reg_file.sv */
module reg_file #(
  parameter int NUM_REGS = 32,
  localparam int IDX_W   = $clog2(NUM_REGS)
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic [IDX_W-1:0] i_rs1_idx,
  output logic [31:0]      o_rs1_data,
  input  logic [IDX_W-1:0] i_rs2_idx,
  output logic [31:0]      o_rs2_data,
  input  logic [IDX_W-1:0] i_host_idx,
  output logic [31:0]      o_host_data,
  input  logic             i_wr_en,
  input  logic [IDX_W-1:0] i_rd_idx,
  input  logic [31:0]      i_rd_data
);

  logic [31:0] regs [NUM_REGS];

  // Entry 0 is cleared by reset and never written, so x0 reads as zero.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && (i_rd_idx != '0)) begin
      regs[i_rd_idx] <= i_rd_data;
    end
  end

  assign o_rs1_data  = regs[i_rs1_idx];
  assign o_rs2_data  = regs[i_rs2_idx];
  assign o_host_data = regs[i_host_idx];

endmodule

/* hdl/exec_apb_regs.sv */
module exec_apb_regs import rv_exec_pkg::*; #(
  parameter int NUM_REGS = 32,
  localparam int IDX_W   = $clog2(NUM_REGS)
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_psel,
  input  logic             i_penable,
  input  logic             i_pwrite,
  input  logic [7:0]       i_paddr,
  input  logic [31:0]      i_pwdata,
  output logic [31:0]      o_prdata,
  output logic             o_pready,
  output logic             o_pslverr,
  output exec_req_t        o_req,
  input  exec_rsp_t        i_rsp,
  output logic [IDX_W-1:0] o_host_idx,
  input  logic [31:0]      i_host_data
);

  logic             access;
  logic             addr_hit;
  logic             bad;
  logic             wr_ok;
  logic             rd_ok;
  logic             req_valid_q;
  logic [31:0]      instr_q;
  logic [IDX_W-1:0] rsel_q;
  logic             taken_q;
  logic             illegal_q;
  logic             clr_illegal;

  // ==================================================
  // Access decode
  // ==================================================
  assign access   = i_psel && i_penable;
  assign addr_hit = (i_paddr == REG_INSTR) || (i_paddr == REG_STATUS) ||
                    (i_paddr == REG_RSEL)  || (i_paddr == REG_RDATA);
  assign bad      = !addr_hit || (i_pwrite && i_paddr == REG_RDATA) ||
                    (!i_pwrite && i_paddr == REG_INSTR);

  assign wr_ok = access && i_pwrite && !bad;
  assign rd_ok = access && !i_pwrite && !bad;

  assign o_pready  = 1'b1;  // Zero wait states.
  assign o_pslverr = access && bad;

  assign clr_illegal = wr_ok && (i_paddr == REG_STATUS) && i_pwdata[1];

  // ==================================================
  // State
  // ==================================================
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_valid_q <= 1'b0;
      rsel_q      <= '0;
      taken_q     <= 1'b0;
      illegal_q   <= 1'b0;
    end else begin
      req_valid_q <= wr_ok && (i_paddr == REG_INSTR);  // One-cycle launch pulse.
      if (wr_ok && (i_paddr == REG_RSEL)) begin
        rsel_q <= IDX_W'(i_pwdata % 32'(NUM_REGS));
      end
      if (i_rsp.done) begin
        taken_q <= i_rsp.taken;
      end
      illegal_q <= (illegal_q && !clr_illegal) || (i_rsp.done && i_rsp.illegal);
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_ok && (i_paddr == REG_INSTR)) begin
      instr_q <= i_pwdata;
    end
  end

  assign o_req      = '{valid: req_valid_q, instr: instr_q};
  assign o_host_idx = rsel_q;

  // Read mux.
  always_comb begin
    o_prdata = '0;
    if (rd_ok) begin
      case (i_paddr)
        REG_STATUS: o_prdata = {30'b0, illegal_q, taken_q};
        REG_RSEL:   o_prdata = 32'(rsel_q);
        REG_RDATA:  o_prdata = i_host_data;
        default:    o_prdata = '0;
      endcase
    end
  end

endmodule

/* hdl/exec_core.sv */
module exec_core import rv_exec_pkg::*; #(
  parameter int NUM_REGS = 32,
  localparam int IDX_W   = $clog2(NUM_REGS)
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  exec_req_t        i_req,
  output exec_rsp_t        o_rsp,
  input  logic [IDX_W-1:0] i_host_idx,
  output logic [31:0]      o_host_data
);

  decode_t     dec;
  logic [31:0] imm;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] op_b;
  logic [31:0] result;
  logic        alu_taken;
  logic        rs1_used;
  logic        rs2_used;
  logic        idx_bad;
  logic        illegal;
  logic        wr_en;

  instruction_decode u_decode (
    .i_instr (i_req.instr),
    .o_dec   (dec)
  );

  immediate_gen u_imm (
    .i_instr (i_req.instr),
    .i_class (dec.instr_class),
    .o_imm   (imm)
  );

  // Register indices past the end only matter for RV32E.
  assign rs1_used = (dec.instr_class == CLS_REG) || (dec.instr_class == CLS_IMM) ||
                    (dec.instr_class == CLS_BRANCH);
  assign rs2_used = (dec.instr_class == CLS_REG) || (dec.instr_class == CLS_BRANCH);
  assign idx_bad  = (dec.wr_en && (32'(dec.rd) >= NUM_REGS)) ||
                    (rs1_used && (32'(dec.rs1) >= NUM_REGS)) ||
                    (rs2_used && (32'(dec.rs2) >= NUM_REGS));

  assign illegal = (dec.instr_class == CLS_ILLEGAL) || idx_bad;
  assign wr_en   = i_req.valid && dec.wr_en && !illegal;
  assign op_b    = dec.use_imm ? imm : rs2_data;

  int_alu u_alu (
    .i_a      (rs1_data),
    .i_b      (op_b),
    .i_op     (dec.alu_op),
    .i_br     (dec.branch_op),
    .o_result (result),
    .o_taken  (alu_taken)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_regs (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_rs1_idx   (dec.rs1[IDX_W-1:0]),
    .o_rs1_data  (rs1_data),
    .i_rs2_idx   (dec.rs2[IDX_W-1:0]),
    .o_rs2_data  (rs2_data),
    .i_host_idx  (i_host_idx),
    .o_host_data (o_host_data),
    .i_wr_en     (wr_en),
    .i_rd_idx    (dec.rd[IDX_W-1:0]),
    .i_rd_data   (result)
  );

  // Answer in the launch cycle.
  assign o_rsp = '{done:    i_req.valid,
                   taken:   i_req.valid && alu_taken && !illegal,
                   illegal: i_req.valid && illegal};

endmodule

/* hdl/rv_exec_top.sv */
module rv_exec_top import rv_exec_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [7:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr
);

  localparam int IDX_W = $clog2(NUM_REGS);

  exec_req_t        req;
  exec_rsp_t        rsp;
  logic [IDX_W-1:0] host_idx;
  logic [31:0]      host_data;

  exec_apb_regs #(.NUM_REGS(NUM_REGS)) u_apb_regs (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_req       (req),
    .i_rsp       (rsp),
    .o_host_idx  (host_idx),
    .i_host_data (host_data)
  );

  exec_core #(.NUM_REGS(NUM_REGS)) u_core (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_req       (req),
    .o_rsp       (rsp),
    .i_host_idx  (host_idx),
    .o_host_data (host_data)
  );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

  // Release a little after an edge.
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #10;
    o_arst_n = 1'b1;
  end

endmodule

/* test/rv_exec_assertions.sv */
module rv_exec_assertions import rv_exec_pkg::*; (
  input logic      i_clk,
  input logic      i_arst_n,
  input logic      i_psel,
  input logic      i_penable,
  input logic      i_pready,
  input logic      i_pslverr,
  input exec_req_t i_req,
  input exec_rsp_t i_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  int err_count = 0;

  // ==================================================
  // APB
  // ==================================================
  pready_high: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_pready)
    else begin
      $error("o_pready went low");
      err_count++;
    end

  pslverr_in_access: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_pslverr |-> (i_psel && i_penable))
    else begin
      $error("o_pslverr outside the access phase");
      err_count++;
    end

  // ==================================================
  // Execute handshake
  // ==================================================
  valid_one_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_req.valid |=> !i_req.valid)
    else begin
      $error("Request valid held longer than one cycle");
      err_count++;
    end

  done_with_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp.done == i_req.valid)
    else begin
      $error("Response done not aligned with request valid");
      err_count++;
    end

endmodule

/* test/rv_exec_tb.sv */
module rv_exec_tb import rv_exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REGS  = 32;
  localparam int DRIVE_DLY = 10;
  localparam int N_RAND    = 64;
  localparam int N_ILL     = 10;

  // Transfers per phase, two cycles each.
  localparam int N_XFER = (1 + 2 * 32)          // Reset values.
                        + (31 * 4 + 2 * 3)      // LUI seeding and x0 writes.
                        + (N_RAND * 3)          // Random ALU ops.
                        + (4 + 24 * 2 + 2 * 32) // Branches.
                        + (N_ILL * 5 + 2 * 32)  // Illegal words.
                        + (5 + 2 + 3 + 2 * 32); // Slave errors.
  localparam int MAX_CYCLES = 4 * N_XFER * 2;

  localparam logic [31:0] NOP = 32'h0000_0013;  // ADDI x0, x0, 0.

  localparam logic [2:0] BR_F3  [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam logic [4:0] PAIR_A [4] = '{5'd1, 5'd1, 5'd3, 5'd4};
  localparam logic [4:0] PAIR_B [4] = '{5'd2, 5'd4, 5'd4, 5'd3};

  localparam logic [31:0] ILLEGAL_WORDS [N_ILL] = '{
    {12'h004, 5'd1, 3'b010, 5'd6, 7'b0000011},        // LW
    {7'h00, 5'd2, 5'd1, 3'b010, 5'd8, 7'b0100011},    // SW
    {20'h00100, 5'd7, 7'b1101111},                    // JAL
    {12'h010, 5'd1, 3'b000, 5'd7, 7'b1100111},        // JALR
    {20'h12345, 5'd9, 7'b0010111},                    // AUIPC
    {7'h01, 5'd2, 5'd1, 3'b000, 5'd10, 7'b0110011},   // ADD, funct7 01
    {7'h20, 5'd3, 5'd1, 3'b001, 5'd12, 7'b0010011},   // SLLI, funct7 20
    {7'h10, 5'd3, 5'd1, 3'b101, 5'd13, 7'b0010011},   // SRAI, funct7 10
    32'h0FF0_000F,                                    // FENCE
    32'h0000_0073                                     // ECALL
  };

  typedef struct packed {
    logic        chk_data;
    logic [31:0] data;
    logic        err;
  } apb_exp_t;

  typedef struct packed {
    logic        wr;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        taken;
    logic        illegal;
  } exec_exp_t;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] model_regs [32];
  logic        model_taken;
  logic        model_illegal;
  logic [4:0]  model_rsel;

  apb_exp_t    exp_q [$];
  string       label_q [$];
  int          cycle_count = 0;
  int          assert_errs;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock_gen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  rv_exec_top #(.NUM_REGS(NUM_REGS)) rv_exec_top_inst (
    .i_clk     (clk),
    .i_arst_n  (arst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr)
  );

  bind exec_apb_regs rv_exec_assertions u_assertions (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pready  (o_pready),
    .i_pslverr (o_pslverr),
    .i_req     (o_req),
    .i_rsp     (i_rsp)
  );

  assign assert_errs = rv_exec_top_inst.u_apb_regs.u_assertions.err_count;

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [4:0]  sh;
    sh = b[4:0];  // RV32I shifts use five bits.
    case (f3)
      3'd0: r = alt ? (a - b) : (a + b);
      3'd1: r = a << sh;
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> sh;
        end else begin
          r = a >> sh;
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic exec_exp_t ref_exec(input logic [31:0] instr);
    exec_exp_t   r;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic        legal;
    f7    = instr[31:25];
    f3    = instr[14:12];
    a     = model_regs[instr[19:15]];
    b     = model_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    r     = '0;
    r.rd  = instr[11:7];
    legal = 1'b0;
    case (instr[6:0])
      7'b0110011: begin
        legal   = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        r.wr    = 1'b1;
        r.value = alu_ref(f3, f7[5], a, b);
      end
      7'b0010011: begin
        legal   = (f3 == 3'd1) ? (f7 == 7'h00) :
                  (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        r.wr    = 1'b1;
        r.value = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm_i);
      end
      7'b0110111: begin
        legal   = 1'b1;
        r.wr    = 1'b1;
        r.value = {instr[31:12], 12'h000};
      end
      7'b1100011: begin
        legal = (f3 != 3'd2) && (f3 != 3'd3);
        case (f3)
          3'd0:    r.taken = (a == b);
          3'd1:    r.taken = (a != b);
          3'd4:    r.taken = ($signed(a) < $signed(b));
          3'd5:    r.taken = ($signed(a) >= $signed(b));
          3'd6:    r.taken = (a < b);
          3'd7:    r.taken = (a >= b);
          default: r.taken = 1'b0;
        endcase
      end
      default: legal = 1'b0;  // No memory, no PC, no system ops.
    endcase
    r.illegal = !legal;
    r.wr      = r.wr && legal && (r.rd != 5'd0);
    r.taken   = r.taken && legal;
    return r;
  endfunction

  // ==================================================
  // Checking
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Errors found");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  always @(negedge clk) begin : compare
    apb_exp_t e;
    string    label;
    if (assert_errs != 0) begin
      $display("A bound assertion on the APB block failed.");
      $display("Errors found");
      $fatal(1, "Assertion failure.");
    end else if (psel && penable) begin
      if (exp_q.size() == 0) begin
        $display("An APB access phase occurred with no expected result queued.");
        $display("Errors found");
        $fatal(1, "Unexpected transfer.");
      end else begin
        e     = exp_q.pop_front();
        label = label_q.pop_front();
        check_value($sformatf("o_pready (%s)", label), 32'(pready), 32'h1);
        check_value($sformatf("o_pslverr (%s)", label), 32'(pslverr), 32'(e.err));
        if (e.chk_data) begin
          check_value($sformatf("o_prdata (%s)", label), prdata, e.data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
      $display("Errors found");
      $fatal(1, "Timeout.");
    end
  end

  // ==================================================
  // APB driver
  // ==================================================
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          input logic chk, input logic [31:0] exp_data, input logic exp_err,
                          input string label);
    apb_exp_t e;
    e.chk_data = chk;
    e.data     = exp_data;
    e.err      = exp_err;
    exp_q.push_back(e);
    label_q.push_back(label);
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    penable = 1'b1;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input string label);
    apb_xfer(1'b1, addr, data, 1'b0, 32'h0, 1'b0, label);
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input string label);
    apb_xfer(1'b0, addr, 32'h0, 1'b1, exp, 1'b0, label);
  endtask

  task automatic apb_bad(input logic wr, input logic [7:0] addr, input string label);
    apb_xfer(wr, addr, $urandom, 1'b0, 32'h0, 1'b1, label);
  endtask

  task automatic apb_idle();
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic exec_instr(input logic [31:0] instr);
    exec_exp_t r;
    r = ref_exec(instr);
    if (r.wr) begin
      model_regs[r.rd] = r.value;
    end
    model_taken   = r.taken;
    model_illegal = model_illegal || r.illegal;
    apb_write(REG_INSTR, instr, $sformatf("INSTR 0x%08h", instr));
  endtask

  task automatic check_reg(input int idx);
    model_rsel = 5'(idx);
    apb_write(REG_RSEL, 32'(idx), "RSEL");
    apb_read(REG_RDATA, model_regs[idx], $sformatf("x%0d", idx));
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < 32; i++) begin
      check_reg(i);
    end
  endtask

  task automatic check_status();
    apb_read(REG_STATUS, {30'b0, model_illegal, model_taken}, "STATUS");
  endtask

  function automatic logic [31:0] rand_alu_instr(input int i);
    logic [2:0]  f3;
    logic        is_r;
    logic        alt;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic [31:0] rnd;
    f3   = 3'(i % 8);
    is_r = ((i / 8) % 2) == 0;
    alt  = ((i / 16) % 2) == 1;  // SUB and SRA(I) in the second half.
    rnd  = $urandom;
    rd   = (rnd[4:0] == 5'd0) ? 5'd31 : rnd[4:0];
    imm  = rnd[26:15];
    if (is_r) begin
      return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
              rnd[14:10], rnd[9:5], f3, rd, 7'b0110011};
    end
    if (f3 == 3'd1) begin
      imm = {7'h00, imm[4:0]};
    end else if (f3 == 3'd5) begin
      imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
    end
    return {imm, rnd[9:5], f3, rd, 7'b0010011};
  endfunction

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    logic [31:0] rnd;
    void'($urandom(20919));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'h00;
    pwdata  = 32'h0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'h0;
    end
    model_taken   = 1'b0;
    model_illegal = 1'b0;
    model_rsel    = 5'd0;
    @(posedge arst_n);

    check_status();
    check_all_regs();

    // Seed every register through LUI, then add a low part.
    for (int r = 1; r < 32; r++) begin
      rnd = $urandom;
      exec_instr({rnd[31:12], 5'(r), 7'b0110111});
      check_reg(r);
      exec_instr({rnd[11:0], 5'(r), 3'b000, 5'(r), 7'b0010011});
    end
    exec_instr({20'hABCDE, 5'd0, 7'b0110111});
    check_reg(0);
    exec_instr({12'd123, 5'd5, 3'b000, 5'd0, 7'b0010011});
    check_reg(0);

    for (int i = 0; i < N_RAND; i++) begin
      rnd = rand_alu_instr(i);
      exec_instr(rnd);
      check_reg(int'(rnd[11:7]));
    end

    // Operands x1 = x2 = 5, x3 = -1, x4 = 1.
    exec_instr({12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011});
    exec_instr({12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011});
    exec_instr({12'hFFF, 5'd0, 3'b000, 5'd3, 7'b0010011});
    exec_instr({12'd1, 5'd0, 3'b000, 5'd4, 7'b0010011});
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 4; p++) begin
        rnd = $urandom;
        exec_instr({rnd[6:0], PAIR_B[p], PAIR_A[p], BR_F3[c], rnd[11:7], 7'b1100011});
        check_status();
      end
    end
    check_all_regs();

    // Sticky flag survives a legal op, then clears on write.
    for (int i = 0; i < N_ILL; i++) begin
      exec_instr(ILLEGAL_WORDS[i]);
      exec_instr(NOP);
      check_status();
      apb_write(REG_STATUS, 32'h2, "STATUS clear");
      model_illegal = 1'b0;
      check_status();
    end
    check_all_regs();

    apb_bad(1'b0, 8'h10, "read 0x10");
    apb_bad(1'b1, 8'h14, "write 0x14");
    apb_bad(1'b1, 8'h01, "write 0x01");
    apb_bad(1'b0, REG_INSTR, "read INSTR");
    apb_bad(1'b1, REG_RDATA, "write RDATA");
    check_status();
    apb_read(REG_RSEL, {27'b0, model_rsel}, "RSEL");
    apb_write(REG_RSEL, 32'd37, "RSEL wrap");
    model_rsel = 5'(37 % NUM_REGS);
    apb_read(REG_RSEL, {27'b0, model_rsel}, "RSEL wrap");
    apb_read(REG_RDATA, model_regs[model_rsel], "x5 after wrap");
    check_all_regs();

    apb_idle();
    @(posedge clk);
    if (exp_q.size() != 0 || assert_errs != 0) begin
      $display("The run ended with unchecked transfers or assertion failures.");
      $display("Errors found");
      $fatal(1, "Run incomplete.");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* verilog.f */
hdl/rv_exec_pkg.sv
hdl/instruction_decode.sv
hdl/immediate_gen.sv
hdl/int_alu.sv
hdl/reg_file.sv
hdl/exec_apb_regs.sv
hdl/exec_core.sv
hdl/rv_exec_top.sv
test/tb_clock_gen.sv
test/rv_exec_assertions.sv
test/rv_exec_tb.sv

/* Makefile */
# Verilator flow for the RV32I execute unit.

VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Status comes from the search for the pass line.
sim: build
	$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
